//--- project.f
+incdir+verif
verilog/mc_bridge_pkg.sv
verilog/host_req_packer.sv
verilog/net_to_host_unpacker.sv
verilog/mmio_dispatch.sv
verilog/host_mc_bridge.sv
verif/host_mc_bridge_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the bridge testbench with Verilator, run it, then search the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f project.f --top-module host_mc_bridge_tb \
  -o host_mc_bridge_tb_sim > build.log 2>&1 &&
  ./obj_dir/host_mc_bridge_tb_sim > sim.log 2>&1 ||
  { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }
grep -q "Test completed successfully" sim.log && echo "PASS" ||
  { echo "FAIL"; exit 1; }

//--- verif/bridge_tb_checks.svh
`ifndef bridge_tb_checks_svh
`define bridge_tb_checks_svh

//////////////////////////////////////////////////
// Compares
//////////////////////////////////////////////////
task automatic stop_on_error(input string msg);
  $display("%s", msg);
  $display("Test failed");
  $fatal(1, "Simulation stopped at the first error");
endtask

task automatic check_word(input string name, input mc_bridge_pkg::rev_reply_s got,
                          input mc_bridge_pkg::rev_reply_s exp);
  if (got !== exp)
    stop_on_error($sformatf("Fail at %0t ns: %s got %h expected %h",
                            $time, name, got.data, exp.data));
endtask

task automatic check_req_pkt(input string name, input mc_bridge_pkg::net_req_pkt_u got,
                             input mc_bridge_pkg::net_req_pkt_u exp);
  if (got !== exp)
    stop_on_error($sformatf("Fail at %0t ns: %s got %h expected %h",
                            $time, name, got.words, exp.words));
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp)
    stop_on_error($sformatf("Fail at %0t ns: %s got %b expected %b",
                            $time, name, got, exp));
endtask

//////////////////////////////////////////////////
// Timed waits, all entered on a falling edge
//////////////////////////////////////////////////
task automatic send_cmd(input logic we, input logic [15:0] addr, input logic [31:0] data);
  int waited;
  waited          = 0;
  fwd_cmd_i.addr  = addr;
  fwd_cmd_i.we    = we;
  fwd_cmd_i.data  = data;
  fwd_v_i         = 1'b1;
  while (!fwd_ready_o)
  begin
    @(negedge clk_i);
    waited++;
    if (waited > timeout_cycles_c)
      stop_on_error("Timeout: the bridge never accepted a host command");
  end
  @(negedge clk_i);
  fwd_v_i = 1'b0;
endtask

task automatic take_reply(output mc_bridge_pkg::rev_reply_s reply);
  int   waited;
  logic done;
  waited = 0;
  done   = 1'b0;
  reply  = '0;
  while (!done)
  begin
    // Ready three cycles out of four
    rev_ready_i = (($urandom % 4) != 0);
    if (rev_v_o && rev_ready_i)
    begin
      reply = rev_reply_o;
      done  = 1'b1;
    end
    @(negedge clk_i);
    waited++;
    if (!done && waited > timeout_cycles_c)
      stop_on_error("Timeout: no reply came back for a host command");
  end
  rev_ready_i = 1'b0;
endtask

task automatic wait_inject_taken(input logic is_req);
  int waited;
  waited = 0;
  @(negedge clk_i);
  while (!(is_req ? in_req_taken : ret_taken))
  begin
    waited++;
    if (waited > timeout_cycles_c)
      stop_on_error("Timeout: the bridge never took an inbound network packet");
    @(negedge clk_i);
  end
endtask

task automatic wait_pkts_out();
  int waited;
  waited = 0;
  while (exp_pkt_q.size() != 0)
  begin
    @(negedge clk_i);
    waited++;
    if (waited > timeout_cycles_c)
      stop_on_error("Timeout: an assembled request packet never left the bridge");
  end
endtask

`endif

//--- verif/host_mc_bridge_tb.sv
`timescale 1ns/1ns

module host_mc_bridge_tb;

  localparam int timeout_cycles_c = 200;

  typedef enum logic [2:0] {
    op_write,
    op_read,
    op_resp_inject,
    op_req_inject,
    op_credit,
    op_read_held
  } op_kind_e;

  // For a credit pulse, expected is the packet count before the pulse
  typedef struct {
    op_kind_e    kind;
    logic [15:0] addr;
    logic [95:0] data;
    logic [31:0] expected;
  } op_t;

  logic                        clk_i;
  logic                        reset_i;
  mc_bridge_pkg::fwd_cmd_s     fwd_cmd_i;
  logic                        fwd_v_i;
  logic                        fwd_ready_o;
  mc_bridge_pkg::rev_reply_s   rev_reply_o;
  logic                        rev_v_o;
  logic                        rev_ready_i;
  mc_bridge_pkg::net_req_pkt_u out_pkt_o;
  logic                        out_v_o;
  logic                        out_credit_i;
  mc_bridge_pkg::net_ret_pkt_u ret_pkt_i;
  logic                        ret_v_i;
  logic                        ret_yumi_o;
  mc_bridge_pkg::net_req_pkt_u in_req_pkt_i;
  logic                        in_req_v_i;
  logic                        in_req_yumi_o;
  logic                        returning_v_o;

  op_t                         ops[$];
  mc_bridge_pkg::net_req_pkt_u exp_pkt_q[$];
  mc_bridge_pkg::rev_reply_s   held_q[$];
  logic [31:0]                 gather_q[$];
  int                          pkt_seen;
  logic                        ret_taken;
  logic                        in_req_taken;

  `include "bridge_tb_checks.svh"

  host_mc_bridge u_host_mc_bridge (.*);

  always #4 clk_i = ~clk_i;

  // Inbound handshakes, sampled like a flop
  always @(posedge clk_i)
  begin
    ret_taken    <= ret_v_i & ret_yumi_o;
    in_req_taken <= in_req_v_i & in_req_yumi_o;
  end

  //////////////////////////////////////////////////
  // Network monitor on the outbound port
  //////////////////////////////////////////////////
  always @(negedge clk_i)
  begin
    if (!reset_i && out_v_o)
    begin
      if (exp_pkt_q.size() == 0)
        stop_on_error("A request packet left the bridge while none was expected");
      else
      begin
        check_req_pkt("out_pkt_o", out_pkt_o, exp_pkt_q[0]);
        exp_pkt_q.delete(0);
        pkt_seen++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Operation table
  //////////////////////////////////////////////////
  task automatic add_op(input op_kind_e kind, input logic [15:0] addr,
                        input logic [95:0] data, input logic [31:0] expected);
    op_t op;
    op.kind     = kind;
    op.addr     = addr;
    op.data     = data;
    op.expected = expected;
    ops.push_back(op);
  endtask

  task automatic add_packet_writes();
    logic [31:0] w;
    for (int i = 0; i < 3; i++)
    begin
      w = $urandom;
      add_op(op_write, mc_bridge_pkg::req_fifo_addr_c, {64'h0, w}, 32'h0);
    end
  endtask

  task automatic build_table();
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    add_op(op_read, mc_bridge_pkg::ep_credits_addr_c, '0, 32'd0);
    add_op(op_read, mc_bridge_pkg::req_credits_addr_c, '0, 32'd1);
    add_packet_writes();
    add_op(op_read, mc_bridge_pkg::ep_credits_addr_c, '0, 32'd1);
    add_op(op_credit, 16'h0, '0, 32'd1);
    add_op(op_read, mc_bridge_pkg::ep_credits_addr_c, '0, 32'd0);
    // Drain the whole credit pool, then one packet more
    repeat (4) add_packet_writes();
    add_op(op_read, mc_bridge_pkg::ep_credits_addr_c, '0, 32'd4);
    add_op(op_read, mc_bridge_pkg::req_credits_addr_c, '0, 32'd1);
    add_packet_writes();
    add_op(op_read, mc_bridge_pkg::req_credits_addr_c, '0, 32'd0);
    add_op(op_credit, 16'h0, '0, 32'd5);
    add_op(op_read, mc_bridge_pkg::ep_credits_addr_c, '0, 32'd4);
    add_op(op_read, mc_bridge_pkg::req_credits_addr_c, '0, 32'd1);
    // Network response
    w0 = $urandom;
    w1 = $urandom;
    add_op(op_resp_inject, 16'h0, {32'h0, w1, w0}, 32'h0);
    add_op(op_read, mc_bridge_pkg::resp_entries_addr_c, '0, 32'd1);
    add_op(op_read, mc_bridge_pkg::resp_fifo_addr_c, '0, w0);
    add_op(op_read, mc_bridge_pkg::resp_fifo_addr_c, '0, w1);
    add_op(op_read, mc_bridge_pkg::resp_entries_addr_c, '0, 32'd0);
    // Network request
    w0 = $urandom;
    w1 = $urandom;
    w2 = $urandom;
    add_op(op_req_inject, 16'h0, {w2, w1, w0}, 32'h0);
    add_op(op_read, mc_bridge_pkg::in_req_entries_addr_c, '0, 32'd1);
    add_op(op_read, mc_bridge_pkg::in_req_fifo_addr_c, '0, w0);
    add_op(op_read, mc_bridge_pkg::in_req_fifo_addr_c, '0, w1);
    add_op(op_read, mc_bridge_pkg::in_req_fifo_addr_c, '0, w2);
    add_op(op_read, mc_bridge_pkg::in_req_entries_addr_c, '0, 32'd0);
    // Unmapped addresses, status unchanged afterwards
    for (int i = 0; i < 3; i++)
    begin
      w0 = $urandom;
      add_op(op_write, 16'h7000, {64'h0, w0}, 32'h0);
    end
    add_op(op_read, 16'h7000, '0, 32'h0);
    add_op(op_read, 16'hfffc, '0, 32'h0);
    add_op(op_read, mc_bridge_pkg::resp_entries_addr_c, '0, 32'd0);
    add_op(op_read, mc_bridge_pkg::in_req_entries_addr_c, '0, 32'd0);
    add_op(op_read, mc_bridge_pkg::ep_credits_addr_c, '0, 32'd4);
    add_op(op_read, mc_bridge_pkg::req_credits_addr_c, '0, 32'd1);
    // Two reads in flight fill the command buffer
    add_op(op_read_held, mc_bridge_pkg::ep_credits_addr_c, '0, 32'd4);
    add_op(op_read, mc_bridge_pkg::req_credits_addr_c, '0, 32'd1);
  endtask

  // Three request words make one packet, word 0 lowest
  task automatic note_req_word(input logic [31:0] word);
    mc_bridge_pkg::net_req_pkt_u pkt;
    gather_q.push_back(word);
    if (gather_q.size() == 3)
    begin
      pkt.words[0] = gather_q[0];
      pkt.words[1] = gather_q[1];
      pkt.words[2] = gather_q[2];
      exp_pkt_q.push_back(pkt);
      gather_q.delete();
    end
  endtask

  task automatic apply_op(input op_t op);
    mc_bridge_pkg::rev_reply_s got;
    mc_bridge_pkg::rev_reply_s exp;
    exp.data = op.expected;
    case (op.kind)
      op_read_held:
      begin
        // Reply stays in the buffer until the next command is in
        send_cmd(1'b0, op.addr, op.data[31:0]);
        held_q.push_back(exp);
      end
      op_write, op_read:
      begin
        if (op.kind == op_write && op.addr == mc_bridge_pkg::req_fifo_addr_c)
          note_req_word(op.data[31:0]);
        send_cmd(op.kind == op_write, op.addr, op.data[31:0]);
        if (held_q.size() == 1)
          check_flag("fwd_ready_o", fwd_ready_o, 1'b0);
        while (held_q.size() != 0)
        begin
          take_reply(got);
          check_word("rev_reply_o", got, held_q[0]);
          held_q.delete(0);
        end
        take_reply(got);
        check_word("rev_reply_o", got, exp);
      end
      op_resp_inject:
      begin
        ret_pkt_i = op.data[63:0];
        ret_v_i   = 1'b1;
        wait_inject_taken(1'b0);
        ret_v_i   = 1'b0;
      end
      op_req_inject:
      begin
        in_req_pkt_i = op.data;
        in_req_v_i   = 1'b1;
        wait_inject_taken(1'b1);
        in_req_v_i   = 1'b0;
        check_flag("returning_v_o", returning_v_o, 1'b1);
        @(negedge clk_i);
        check_flag("returning_v_o", returning_v_o, 1'b0);
      end
      default:
      begin
        if (pkt_seen != op.expected)
          stop_on_error($sformatf("Fail at %0t ns: out_v_o packet count got %0d expected %0d",
                                  $time, pkt_seen, op.expected));
        out_credit_i = 1'b1;
        @(negedge clk_i);
        out_credit_i = 1'b0;
        wait_pkts_out();
      end
    endcase
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial
  begin
    void'($urandom(32'hf8cd8fb1));
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    fwd_cmd_i    = '0;
    fwd_v_i      = 1'b0;
    rev_ready_i  = 1'b0;
    out_credit_i = 1'b0;
    ret_pkt_i    = '0;
    ret_v_i      = 1'b0;
    in_req_pkt_i = '0;
    in_req_v_i   = 1'b0;
    pkt_seen     = 0;
    build_table();
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    check_flag("fwd_ready_o", fwd_ready_o, 1'b1);
    check_flag("rev_v_o", rev_v_o, 1'b0);
    check_flag("out_v_o", out_v_o, 1'b0);
    check_flag("ret_yumi_o", ret_yumi_o, 1'b0);
    check_flag("in_req_yumi_o", in_req_yumi_o, 1'b0);
    check_flag("returning_v_o", returning_v_o, 1'b0);
    foreach (ops[i])
      apply_op(ops[i]);
    if (exp_pkt_q.size() != 0)
      stop_on_error("An assembled request packet never left the bridge");
    else
    begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

//--- verilog/host_mc_bridge.sv
`timescale 1ns/1ns

module host_mc_bridge
  (
    input  logic                        clk_i,
    input  logic                        reset_i,

    input  mc_bridge_pkg::fwd_cmd_s     fwd_cmd_i,
    input  logic                        fwd_v_i,
    output logic                        fwd_ready_o,

    output mc_bridge_pkg::rev_reply_s   rev_reply_o,
    output logic                        rev_v_o,
    input  logic                        rev_ready_i,

    output mc_bridge_pkg::net_req_pkt_u out_pkt_o,
    output logic                        out_v_o,
    input  logic                        out_credit_i,

    input  mc_bridge_pkg::net_ret_pkt_u ret_pkt_i,
    input  logic                        ret_v_i,
    output logic                        ret_yumi_o,

    input  mc_bridge_pkg::net_req_pkt_u in_req_pkt_i,
    input  logic                        in_req_v_i,
    output logic                        in_req_yumi_o,

    output logic                        returning_v_o
  );

  logic                                   req_word_v;
  logic [mc_bridge_pkg::word_width_c-1:0] req_word;
  logic                                   req_ready;
  mc_bridge_pkg::credit_cnt_t             credits_used;

  logic [mc_bridge_pkg::word_width_c-1:0] resp_word;
  logic                                   resp_word_v;
  logic                                   resp_pop;

  logic [mc_bridge_pkg::word_width_c-1:0] in_req_word;
  logic                                   in_req_word_v;
  logic                                   in_req_pop;

  //////////////////////////////////////////////////
  // Host to network
  //////////////////////////////////////////////////
  host_req_packer u_packer (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .word_v_i       (req_word_v),
    .word_i         (req_word),
    .ready_o        (req_ready),
    .out_pkt_o      (out_pkt_o),
    .out_v_o        (out_v_o),
    .out_credit_i   (out_credit_i),
    .credits_used_o (credits_used)
  );

  //////////////////////////////////////////////////
  // Network to host
  //////////////////////////////////////////////////
  net_to_host_unpacker #(.num_words(mc_bridge_pkg::ret_words_c)) u_resp_unpack (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .pkt_i      (ret_pkt_i.words),
    .pkt_v_i    (ret_v_i),
    .pkt_yumi_o (ret_yumi_o),
    .word_o     (resp_word),
    .word_v_o   (resp_word_v),
    .word_pop_i (resp_pop)
  );

  net_to_host_unpacker #(.num_words(mc_bridge_pkg::req_words_c)) u_in_req_unpack (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .pkt_i      (in_req_pkt_i.words),
    .pkt_v_i    (in_req_v_i),
    .pkt_yumi_o (in_req_yumi_o),
    .word_o     (in_req_word),
    .word_v_o   (in_req_word_v),
    .word_pop_i (in_req_pop)
  );

  mmio_dispatch u_dispatch (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .fwd_cmd_i       (fwd_cmd_i),
    .fwd_v_i         (fwd_v_i),
    .fwd_ready_o     (fwd_ready_o),
    .rev_reply_o     (rev_reply_o),
    .rev_v_o         (rev_v_o),
    .rev_ready_i     (rev_ready_i),
    .req_word_v_o    (req_word_v),
    .req_word_o      (req_word),
    .req_ready_i     (req_ready),
    .credits_used_i  (credits_used),
    .resp_word_i     (resp_word),
    .resp_word_v_i   (resp_word_v),
    .resp_pop_o      (resp_pop),
    .in_req_word_i   (in_req_word),
    .in_req_word_v_i (in_req_word_v),
    .in_req_pop_o    (in_req_pop)
  );

  // Ack each network request one cycle after it is taken
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      returning_v_o <= 1'b0;
    else
      returning_v_o <= in_req_yumi_o;
  end

endmodule

//--- verilog/mmio_dispatch.sv
`timescale 1ns/1ns

module mmio_dispatch
  (
    input  logic                                   clk_i,
    input  logic                                   reset_i,

    input  mc_bridge_pkg::fwd_cmd_s                fwd_cmd_i,
    input  logic                                   fwd_v_i,
    output logic                                   fwd_ready_o,

    output mc_bridge_pkg::rev_reply_s              rev_reply_o,
    output logic                                   rev_v_o,
    input  logic                                   rev_ready_i,

    output logic                                   req_word_v_o,
    output logic [mc_bridge_pkg::word_width_c-1:0] req_word_o,
    input  logic                                   req_ready_i,
    input  mc_bridge_pkg::credit_cnt_t             credits_used_i,

    input  logic [mc_bridge_pkg::word_width_c-1:0] resp_word_i,
    input  logic                                   resp_word_v_i,
    output logic                                   resp_pop_o,

    input  logic [mc_bridge_pkg::word_width_c-1:0] in_req_word_i,
    input  logic                                   in_req_word_v_i,
    output logic                                   in_req_pop_o
  );

  //////////////////////////////////////////////////
  // Two-entry command buffer
  //////////////////////////////////////////////////
  mc_bridge_pkg::fwd_cmd_s buf_r [2];
  logic                    wr_ptr_r;
  logic                    rd_ptr_r;
  logic [1:0]              count_r;
  logic                    enq;
  logic                    deq;
  logic                    head_v;
  mc_bridge_pkg::fwd_cmd_s head;

  assign fwd_ready_o = (count_r != 2'd2);
  assign enq         = fwd_v_i & fwd_ready_o;
  assign deq         = rev_v_o & rev_ready_i;
  assign head_v      = (count_r != 2'd0);
  assign head        = buf_r[rd_ptr_r];

  always_ff @(posedge clk_i)
  begin
    if (enq)
    begin
      buf_r[wr_ptr_r] <= fwd_cmd_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= ~wr_ptr_r;
      if (deq)
        rd_ptr_r <= ~rd_ptr_r;
      case ({enq, deq})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Address decode and reply
  //////////////////////////////////////////////////
  always_comb
  begin
    rev_reply_o  = '0;
    rev_v_o      = head_v;
    req_word_v_o = 1'b0;
    req_word_o   = head.data;
    resp_pop_o   = 1'b0;
    in_req_pop_o = 1'b0;

    case (head.addr)
      mc_bridge_pkg::req_fifo_addr_c:
      begin
        // Write stalls while a full packet waits for a credit
        if (head.we)
        begin
          rev_v_o      = head_v & req_ready_i;
          req_word_v_o = rev_v_o & rev_ready_i;
        end
      end
      mc_bridge_pkg::req_credits_addr_c:
        rev_reply_o.data[0] = req_ready_i;
      mc_bridge_pkg::resp_fifo_addr_c:
      begin
        if (!head.we)
        begin
          rev_reply_o.data = resp_word_i;
          rev_v_o          = head_v & resp_word_v_i;
          resp_pop_o       = rev_v_o & rev_ready_i;
        end
      end
      mc_bridge_pkg::resp_entries_addr_c:
        rev_reply_o.data[0] = resp_word_v_i;
      mc_bridge_pkg::in_req_fifo_addr_c:
      begin
        if (!head.we)
        begin
          rev_reply_o.data = in_req_word_i;
          rev_v_o          = head_v & in_req_word_v_i;
          in_req_pop_o     = rev_v_o & rev_ready_i;
        end
      end
      mc_bridge_pkg::in_req_entries_addr_c:
        rev_reply_o.data[0] = in_req_word_v_i;
      mc_bridge_pkg::ep_credits_addr_c:
        rev_reply_o.data[$bits(mc_bridge_pkg::credit_cnt_t)-1:0] = credits_used_i;
      default:
        // Unmapped, zero reply
        rev_reply_o = '0;
    endcase
  end

endmodule

//--- verilog/net_to_host_unpacker.sv
`timescale 1ns/1ns

module net_to_host_unpacker
  #(
    parameter int num_words = 2
  )
  (
    input  logic                                                 clk_i,
    input  logic                                                 reset_i,

    input  logic [num_words-1:0][mc_bridge_pkg::word_width_c-1:0] pkt_i,
    input  logic                                                 pkt_v_i,
    output logic                                                 pkt_yumi_o,

    output logic [mc_bridge_pkg::word_width_c-1:0]               word_o,
    output logic                                                 word_v_o,
    input  logic                                                 word_pop_i
  );

  logic [num_words-1:0][mc_bridge_pkg::word_width_c-1:0] pkt_r;
  mc_bridge_pkg::word_idx_t                              idx_r;
  logic                                                  full_r;
  logic                                                  pop;
  logic                                                  last_pop;

  assign pop      = full_r & word_pop_i;
  assign last_pop = pop & (idx_r == mc_bridge_pkg::word_idx_t'(num_words - 1));

  // Free on the last pop, so a waiting packet can land the same cycle
  assign pkt_yumi_o = pkt_v_i & (~full_r | last_pop);

  assign word_v_o = full_r;
  assign word_o   = pkt_r[idx_r];

  //////////////////////////////////////////////////
  // Holding register
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (pkt_yumi_o)
    begin
      pkt_r <= pkt_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      full_r <= 1'b0;
      idx_r  <= '0;
    end
    else if (pkt_yumi_o)
    begin
      full_r <= 1'b1;
      idx_r  <= '0;
    end
    else if (last_pop)
    begin
      full_r <= 1'b0;
      idx_r  <= '0;
    end
    else if (pop)
    begin
      idx_r <= idx_r + 1'b1;
    end
  end

endmodule

//--- verilog/host_req_packer.sv
`timescale 1ns/1ns

module host_req_packer
  (
    input  logic                        clk_i,
    input  logic                        reset_i,

    input  logic                        word_v_i,
    input  logic [31:0]                 word_i,
    output logic                        ready_o,

    output mc_bridge_pkg::net_req_pkt_u out_pkt_o,
    output logic                        out_v_o,
    input  logic                        out_credit_i,

    output mc_bridge_pkg::credit_cnt_t  credits_used_o
  );

  mc_bridge_pkg::net_req_pkt_u pkt_r;
  mc_bridge_pkg::word_idx_t    word_idx_r;
  mc_bridge_pkg::credit_cnt_t  credits_free_r;
  logic                        full_r;
  logic                        word_take;
  logic                        last_word;

  assign ready_o   = ~full_r;
  assign word_take = word_v_i & ready_o;
  assign last_word = (word_idx_r == mc_bridge_pkg::word_idx_t'(mc_bridge_pkg::req_words_c - 1));

  // Send whenever a full packet sees a free credit
  assign out_v_o   = full_r & (credits_free_r != '0);
  assign out_pkt_o = pkt_r;

  assign credits_used_o = mc_bridge_pkg::max_credits_c - credits_free_r;

  //////////////////////////////////////////////////
  // Word gathering
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (word_take)
    begin
      pkt_r.words[word_idx_r] <= word_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      word_idx_r <= '0;
      full_r     <= 1'b0;
    end
    else if (word_take)
    begin
      if (last_word)
      begin
        word_idx_r <= '0;
        full_r     <= 1'b1;
      end
      else
      begin
        word_idx_r <= word_idx_r + 1'b1;
      end
    end
    else if (out_v_o)
    begin
      full_r <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Credits
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      credits_free_r <= mc_bridge_pkg::max_credits_c;
    end
    else
    begin
      case ({out_v_o, out_credit_i})
        2'b10:   credits_free_r <= credits_free_r - 1'b1;
        2'b01:   credits_free_r <= credits_free_r + 1'b1;
        default: credits_free_r <= credits_free_r;
      endcase
    end
  end

endmodule

//--- verilog/mc_bridge_pkg.sv
package mc_bridge_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////
  localparam int word_width_c     = 32;
  localparam int dev_addr_width_c = 16;
  localparam int req_words_c      = 3;
  localparam int ret_words_c      = 2;

  //////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////
  localparam logic [dev_addr_width_c-1:0] req_fifo_addr_c       = 16'h1000;
  localparam logic [dev_addr_width_c-1:0] req_credits_addr_c    = 16'h2000;
  localparam logic [dev_addr_width_c-1:0] resp_fifo_addr_c      = 16'h3000;
  localparam logic [dev_addr_width_c-1:0] resp_entries_addr_c   = 16'h4000;
  localparam logic [dev_addr_width_c-1:0] in_req_fifo_addr_c    = 16'h5000;
  localparam logic [dev_addr_width_c-1:0] in_req_entries_addr_c = 16'h6000;
  localparam logic [dev_addr_width_c-1:0] ep_credits_addr_c     = 16'h9000;

  // Credit counter, wide enough for the full pool
  typedef logic [2:0] credit_cnt_t;
  localparam credit_cnt_t max_credits_c = 3'd4;

  // Word index within a packet
  typedef logic [1:0] word_idx_t;

  //////////////////////////////////////////////////
  // Host side
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [dev_addr_width_c-1:0] addr;
    logic                        we;
    logic [word_width_c-1:0]     data;
  } fwd_cmd_s;

  typedef struct packed {
    logic [word_width_c-1:0] data;
  } rev_reply_s;

  //////////////////////////////////////////////////
  // Network packets
  //////////////////////////////////////////////////
  typedef enum logic [1:0] {
    e_op_load     = 2'd0,
    e_op_store    = 2'd1,
    e_op_reserved = 2'd2
  } net_op_e;

  // Declared msb first, so x sits in the lowest bits
  typedef struct packed {
    logic [24:0]                 pad;
    logic [dev_addr_width_c-1:0] addr;
    net_op_e                     op;
    logic [4:0]                  reg_id;
    logic [word_width_c-1:0]     payload;
    logic [3:0]                  src_y;
    logic [3:0]                  src_x;
    logic [3:0]                  y;
    logic [3:0]                  x;
  } net_req_pkt_s;

  typedef union packed {
    net_req_pkt_s                                  pkt;
    logic [req_words_c-1:0][word_width_c-1:0]      words;
  } net_req_pkt_u;

  typedef struct packed {
    logic [16:0]             pad;
    logic [1:0]              pkt_type;
    logic [4:0]              reg_id;
    logic [word_width_c-1:0] data;
    logic [3:0]              y;
    logic [3:0]              x;
  } net_ret_pkt_s;

  typedef union packed {
    net_ret_pkt_s                                  pkt;
    logic [ret_words_c-1:0][word_width_c-1:0]      words;
  } net_ret_pkt_u;

endpackage
